// File: vid_overlay.f
hdl/vid_pkg.sv
hdl/vid_ctrl_regs.sv
hdl/vid_source_sel.sv
hdl/vid_alpha_tag.sv
hdl/vid_overlay_mix.sv
hdl/vid_frame_rate.sv
hdl/vid_overlay_top.sv
sim/tb_clk_gen.sv
sim/tb_vid_overlay.sv

// File: run_sim.sh
#!/bin/sh
# Build the Verilator model, run it and look for the pass line in its output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_vid_overlay \
	-f vid_overlay.f -o tb_vid_overlay &&
./obj_dir/tb_vid_overlay | tee /dev/stderr | grep -q "Testbench passed" &&
echo "Simulation PASS" && exit 0 ||
{ echo "Simulation FAIL"; exit 1; }

// File: sim/tb_vid_overlay.sv
// Video overlay testbench with random streams, back-pressure and a pixel model
`timescale 1ns/1ps

module tb_vid_overlay;

	// Four frame rate windows for the meter test, the rest for the short tests
	localparam int TEST_CYCLES = 4 * int'(vid_pkg::WINDOW_CYCLES) + 2000;
	localparam int LIMIT_CYCLES = 3 * TEST_CYCLES;
	localparam int MODE_NONE = 0;
	localparam int MODE_GEN = 1;
	localparam int MODE_STREAM = 2;

	logic               i_clk;
	logic               pix_reset_sys;
	logic               i_bus_stb;
	logic               i_bus_we;
	vid_pkg::bus_addr_t i_bus_addr;
	vid_pkg::bus_data_t i_bus_wdata;
	logic               o_bus_ack;
	vid_pkg::bus_data_t o_bus_rdata;
	logic               i_rx_valid;
	logic               o_rx_ready;
	vid_pkg::pixel_t    i_rx_data;
	logic               i_rx_hlast;
	logic               i_rx_vlast;
	logic               i_ovl_valid;
	logic               o_ovl_ready;
	vid_pkg::pixel_t    i_ovl_data;
	logic               i_ovl_hlast;
	logic               i_ovl_vlast;
	logic               o_vid_valid;
	logic               i_vid_ready;
	vid_pkg::pixel_t    o_vid_data;
	logic               o_vid_hlast;
	logic               o_vid_vlast;

	// One random sequence per process
	logic [31:0] seed_main;
	logic [31:0] seed_ready;
	logic [31:0] seed_rx;
	logic [31:0] seed_ovl;

	int errors = 0;
	int checks = 0;
	int cycle_cnt = 0;

	// Model state
	int              mode;
	logic            mdl_ovly;
	vid_pkg::alpha_t mdl_alpha;
	int              gen_w;
	int              gen_h;
	int              gen_col;
	int              gen_row;
	int              gen_frames;
	// Queued words are vlast, hlast, pixel
	logic [25:0]     rx_q[$];
	logic [25:0]     ovl_q[$];
	vid_pkg::pixel_t rx_pix[64];
	vid_pkg::pixel_t ovl_pix[64];

	tb_clk_gen u_clk_gen (
		.o_clk(i_clk),
		.o_rst(pix_reset_sys)
	);

	vid_overlay_top dut_i (
		.i_clk(i_clk), .pix_reset_sys(pix_reset_sys),
		.i_bus_stb(i_bus_stb), .i_bus_we(i_bus_we),
		.i_bus_addr(i_bus_addr), .i_bus_wdata(i_bus_wdata),
		.o_bus_ack(o_bus_ack), .o_bus_rdata(o_bus_rdata),
		.i_rx_valid(i_rx_valid), .o_rx_ready(o_rx_ready), .i_rx_data(i_rx_data),
		.i_rx_hlast(i_rx_hlast), .i_rx_vlast(i_rx_vlast),
		.i_ovl_valid(i_ovl_valid), .o_ovl_ready(o_ovl_ready), .i_ovl_data(i_ovl_data),
		.i_ovl_hlast(i_ovl_hlast), .i_ovl_vlast(i_ovl_vlast),
		.o_vid_valid(o_vid_valid), .i_vid_ready(i_vid_ready), .o_vid_data(o_vid_data),
		.o_vid_hlast(o_vid_hlast), .o_vid_vlast(o_vid_vlast)
	);

	////////////////////
	// Random numbers
	////////////////////
	function automatic logic [31:0] rand_word(inout logic [31:0] state);
		state = state * 32'd1664525 + 32'd1013904223;
		return state;
	endfunction

	// Upper bits only, the low LCG bits repeat quickly
	function automatic int rand_below(inout logic [31:0] state, input int n);
		logic [31:0] r;
		r = rand_word(state);
		return int'(r[31:16]) % n;
	endfunction

	function automatic vid_pkg::pixel_t rand_pixel(inout logic [31:0] state);
		logic [31:0] r;
		r = rand_word(state);
		return r[31:8];
	endfunction

	////////////////////
	// Checks
	////////////////////
	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else begin
			errors++;
			$display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		checks++;
		assert (cond)
		else begin
			errors++;
			$display("Error at %0t: %s", $time, what);
		end
	endtask

	// Overlay rule, black is see-through, 3 keeps primary, 0 keeps overlay
	function automatic vid_pkg::pixel_t expected_pixel(input vid_pkg::pixel_t p,
		input vid_pkg::pixel_t o, input vid_pkg::alpha_t a);
		vid_pkg::pixel_t res;
		int              sum;
		if (o == vid_pkg::TRANSPARENT || a == vid_pkg::ALPHA_CLEAR)
			return p;
		if (a == vid_pkg::ALPHA_OPAQUE)
			return o;
		// Otherwise a mean per channel, truncated
		for (int k = 0; k < 3; k++) begin
			sum = int'(p[8*k +: 8]) + int'(o[8*k +: 8]);
			res[8*k +: 8] = 8'(sum / 2);
		end
		return res;
	endfunction

	task automatic check_output();
		logic [25:0]     src;
		logic [25:0]     ovl;
		vid_pkg::pixel_t exp;
		logic            exp_h;
		if (mode == MODE_GEN) begin
			// Black frame of the programmed size
			exp_h = (gen_col == gen_w - 1);
			check_value("o_vid_data", 32'(o_vid_data), 32'd0);
			check_value("o_vid_hlast", 32'(o_vid_hlast), 32'(exp_h));
			check_value("o_vid_vlast", 32'(o_vid_vlast), 32'(exp_h && gen_row == gen_h - 1));
			if (!exp_h) begin
				gen_col++;
			end else begin
				gen_col = 0;
				if (gen_row == gen_h - 1) begin
					gen_row = 0;
					gen_frames++;
				end else begin
					gen_row++;
				end
			end
		end else begin
			check_true(mode == MODE_STREAM && rx_q.size() != 0,
				"output pixel with no primary pixel pending");
			if (rx_q.size() != 0) begin
				src = rx_q.pop_front();
				exp = src[23:0];
				if (mdl_ovly) begin
					check_true(ovl_q.size() != 0, "output pixel with no overlay pixel pending");
					if (ovl_q.size() != 0) begin
						ovl = ovl_q.pop_front();
						exp = expected_pixel(src[23:0], ovl[23:0], mdl_alpha);
					end
				end
				check_value("o_vid_data", 32'(o_vid_data), 32'(exp));
				check_value("o_vid_hlast", 32'(o_vid_hlast), 32'(src[24]));
				check_value("o_vid_vlast", 32'(o_vid_vlast), 32'(src[25]));
			end
		end
	endtask

	// Back-pressure and output capture, both on the falling edge
	always @(negedge i_clk) begin
		if (!pix_reset_sys) begin
			i_vid_ready = (rand_below(seed_ready, 4) != 0);
			// Pixel leaves on the next rising edge
			if (o_vid_valid && i_vid_ready)
				check_output();
		end
	end

	always @(posedge i_clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= LIMIT_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", LIMIT_CYCLES);
			$display("Checks: %0d, errors: %0d", checks, errors);
			$display("Testbench failed");
			$finish;
		end
	end

	////////////////////
	// Bus and streams
	////////////////////
	// Ack expected exactly two cycles after the strobe
	task automatic bus_access(input logic we, input vid_pkg::bus_addr_t addr,
		input vid_pkg::bus_data_t wd, output vid_pkg::bus_data_t rd);
		i_bus_stb = 1'b1;
		i_bus_we = we;
		i_bus_addr = addr;
		i_bus_wdata = wd;
		@(negedge i_clk);
		i_bus_stb = 1'b0;
		check_value("o_bus_ack", 32'(o_bus_ack), 32'd0);
		@(negedge i_clk);
		check_value("o_bus_ack", 32'(o_bus_ack), 32'd1);
		rd = o_bus_rdata;
	endtask

	// Ready sampled 1 ns after the falling edge, settled before the rising edge
	task automatic send_rx(input vid_pkg::pixel_t d, input logic hl, input logic vl);
		while (rand_below(seed_rx, 4) == 0)
			@(negedge i_clk);
		i_rx_valid = 1'b1;
		i_rx_data = d;
		i_rx_hlast = hl;
		i_rx_vlast = vl;
		#1;
		while (!o_rx_ready) begin
			@(negedge i_clk);
			#1;
		end
		rx_q.push_back({vl, hl, d});
		@(negedge i_clk);
		i_rx_valid = 1'b0;
	endtask

	task automatic send_ovl(input vid_pkg::pixel_t d, input logic hl, input logic vl);
		while (rand_below(seed_ovl, 4) == 0)
			@(negedge i_clk);
		i_ovl_valid = 1'b1;
		i_ovl_data = d;
		i_ovl_hlast = hl;
		i_ovl_vlast = vl;
		#1;
		while (!o_ovl_ready) begin
			@(negedge i_clk);
			#1;
		end
		ovl_q.push_back({vl, hl, d});
		@(negedge i_clk);
		i_ovl_valid = 1'b0;
	endtask

	task automatic fill_frames(input int n, input logic alt_clear);
		for (int i = 0; i < n; i++) begin
			rx_pix[i] = rand_pixel(seed_main);
			if ((alt_clear && (i % 2 == 0)) || (rand_below(seed_main, 8) == 0))
				ovl_pix[i] = vid_pkg::TRANSPARENT;
			else
				ovl_pix[i] = rand_pixel(seed_main);
		end
	endtask

	task automatic wait_drain();
		while (rx_q.size() != 0 || o_vid_valid)
			@(negedge i_clk);
		check_value("overlay queue size", 32'(ovl_q.size()), 32'd0);
	endtask

	// Short overlay frame ends one pixel early, a padding pixel pairs the last primary
	task automatic run_frames(input int w, input int h, input logic short_ovl);
		int n;
		n = w * h;
		fork
			for (int i = 0; i < n; i++)
				send_rx(rx_pix[i], (i % w) == w - 1, i == n - 1);
			begin
				for (int i = 0; i < n - short_ovl; i++)
					send_ovl(ovl_pix[i], ((i % w) == w - 1) || (i == n - short_ovl - 1),
						i == n - short_ovl - 1);
				if (short_ovl)
					send_ovl(ovl_pix[n - 1], 1'b1, 1'b1);
			end
		join
		wait_drain();
	endtask

	////////////////////
	// Test sequence
	////////////////////
	initial begin
		vid_pkg::bus_data_t rd;
		logic [31:0]        wd;
		int                 w;
		int                 h;
		int                 a;
		int                 c;
		int                 target;
		seed_main = 32'heaab;
		seed_ready = 32'heaab ^ 32'h1;
		seed_rx = 32'heaab ^ 32'h2;
		seed_ovl = 32'heaab ^ 32'h3;
		i_bus_stb = 1'b0;
		i_bus_we = 1'b0;
		i_bus_addr = '0;
		i_bus_wdata = '0;
		i_rx_valid = 1'b0;
		i_rx_data = '0;
		i_rx_hlast = 1'b0;
		i_rx_vlast = 1'b0;
		i_ovl_valid = 1'b0;
		i_ovl_data = '0;
		i_ovl_hlast = 1'b0;
		i_ovl_vlast = 1'b0;
		i_vid_ready = 1'b0;
		mode = MODE_NONE;
		mdl_ovly = 1'b0;
		mdl_alpha = '0;
		@(negedge pix_reset_sys);
		@(negedge i_clk);

		// Readback, select kept at 1 so the generator stays idle
		for (int i = 0; i < 6; i++) begin
			wd = rand_word(seed_main) | 32'h1;
			bus_access(1'b1, vid_pkg::ADR_CONTROL, wd, rd);
			bus_access(1'b0, vid_pkg::ADR_CONTROL, '0, rd);
			check_value("CONTROL readback", rd, wd & 32'h0000_0033);
			wd = rand_word(seed_main);
			bus_access(1'b1, vid_pkg::ADR_SIZE, wd, rd);
			bus_access(1'b0, vid_pkg::ADR_SIZE, '0, rd);
			check_value("SIZE readback", rd, wd & 32'h0fff_0fff);
		end

		// Empty frames from the generator
		w = 1 + rand_below(seed_main, 5);
		h = 1 + rand_below(seed_main, 3);
		bus_access(1'b1, vid_pkg::ADR_SIZE, {4'd0, 12'(h), 4'd0, 12'(w)}, rd);
		gen_w = w;
		gen_h = h;
		gen_col = 0;
		gen_row = 0;
		gen_frames = 0;
		mode = MODE_GEN;
		bus_access(1'b1, vid_pkg::ADR_CONTROL, 32'h0, rd);
		while (gen_frames < 3)
			@(negedge i_clk);
		bus_access(1'b1, vid_pkg::ADR_CONTROL, 32'h1, rd);
		wait_drain();

		// Blending for every alpha code
		mode = MODE_STREAM;
		mdl_ovly = 1'b1;
		for (a = 0; a < 4; a++) begin
			mdl_alpha = 2'(a);
			bus_access(1'b1, vid_pkg::ADR_CONTROL, 32'h3 | (32'(a) << 4), rd);
			w = 2 + rand_below(seed_main, 4);
			h = 1 + rand_below(seed_main, 3);
			fill_frames(w * h, 1'b0);
			run_frames(w, h, 1'b0);
		end

		// Black overlay pixels on every other position
		a = rand_below(seed_main, 3);
		mdl_alpha = 2'(a);
		bus_access(1'b1, vid_pkg::ADR_CONTROL, 32'h3 | (32'(a) << 4), rd);
		w = 2 + rand_below(seed_main, 4);
		h = 1 + rand_below(seed_main, 3);
		fill_frames(w * h, 1'b1);
		run_frames(w, h, 1'b0);

		// Framing error and its clear
		bus_access(1'b0, vid_pkg::ADR_STATUS, '0, rd);
		check_value("STATUS before error", rd, 32'd0);
		w = 2 + rand_below(seed_main, 4);
		h = 1 + rand_below(seed_main, 3);
		fill_frames(w * h, 1'b0);
		run_frames(w, h, 1'b1);
		bus_access(1'b0, vid_pkg::ADR_STATUS, '0, rd);
		check_value("STATUS after short frame", rd, 32'd1);
		bus_access(1'b1, vid_pkg::ADR_STATUS, 32'h1, rd);
		bus_access(1'b0, vid_pkg::ADR_STATUS, '0, rd);
		check_value("STATUS after clear", rd, 32'd0);

		// Frame rate, single pixel frames until a window saturates
		mdl_ovly = 1'b0;
		bus_access(1'b1, vid_pkg::ADR_CONTROL, 32'h1, rd);
		rd = '0;
		while (rd[7:0] != 8'hff) begin
			send_rx(rand_pixel(seed_main), 1'b1, 1'b1);
			bus_access(1'b0, vid_pkg::ADR_FPS, '0, rd);
		end
		// Quiet until the next window end, which leaves a small count
		while (rd[7:0] == 8'hff)
			bus_access(1'b0, vid_pkg::ADR_FPS, '0, rd);
		c = int'(rd[7:0]);
		target = 3 + rand_below(seed_main, 8);
		if (target == c)
			target++;
		for (int i = 0; i < target; i++)
			send_rx(rand_pixel(seed_main), 1'b1, 1'b1);
		while (int'(rd[7:0]) == c)
			bus_access(1'b0, vid_pkg::ADR_FPS, '0, rd);
		check_value("FPS", rd, 32'(target));
		wait_drain();

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// File: sim/tb_clk_gen.sv
// Testbench clock and reset source, 4 ns period with reset held for 5 cycles
`timescale 1ns/1ps

module tb_clk_gen (
	output logic o_clk,
	output logic o_rst
);

	initial begin
		o_clk = 1'b0;
		forever #2 o_clk = ~o_clk;
	end

	// Reset drops on a falling edge, away from the sampling edge
	initial begin
		o_rst = 1'b1;
		repeat (5) @(posedge o_clk);
		@(negedge o_clk);
		o_rst = 1'b0;
	end

endmodule

// File: hdl/vid_overlay_top.sv
// Video overlay top level with source stage, alpha tagging, mixer, meter and registers
`timescale 1ns/1ps

module vid_overlay_top (
	input  logic               i_clk,
	input  logic               pix_reset_sys,
	// Control bus
	input  logic               i_bus_stb,
	input  logic               i_bus_we,
	input  vid_pkg::bus_addr_t i_bus_addr,
	input  vid_pkg::bus_data_t i_bus_wdata,
	output logic               o_bus_ack,
	output vid_pkg::bus_data_t o_bus_rdata,
	// Primary input
	input  logic               i_rx_valid,
	output logic               o_rx_ready,
	input  vid_pkg::pixel_t    i_rx_data,
	input  logic               i_rx_hlast,
	input  logic               i_rx_vlast,
	// Overlay input
	input  logic               i_ovl_valid,
	output logic               o_ovl_ready,
	input  vid_pkg::pixel_t    i_ovl_data,
	input  logic               i_ovl_hlast,
	input  logic               i_ovl_vlast,
	// Mixed output
	output logic               o_vid_valid,
	input  logic               i_vid_ready,
	output vid_pkg::pixel_t    o_vid_data,
	output logic               o_vid_hlast,
	output logic               o_vid_vlast
);

	// Configuration
	logic            cfg_src_sel;
	logic            cfg_ovly_en;
	vid_pkg::alpha_t cfg_alpha;
	vid_pkg::dim_t   cfg_width;
	vid_pkg::dim_t   cfg_height;
	logic            err_clr;
	logic            ovly_err;
	vid_pkg::fps_t   fps;
	logic            rx_frame;

	// Primary stream into the mixer
	logic            src_valid;
	logic            src_ready;
	vid_pkg::pixel_t src_data;
	logic            src_hlast;
	logic            src_vlast;

	// Tagged overlay stream
	logic            tag_valid;
	logic            tag_ready;
	vid_pkg::pixel_t tag_data;
	vid_pkg::alpha_t tag_alpha;
	logic            tag_hlast;
	logic            tag_vlast;

	vid_ctrl_regs u_regs (
		.i_clk(i_clk), .pix_reset_sys(pix_reset_sys),
		.i_bus_stb(i_bus_stb), .i_bus_we(i_bus_we),
		.i_bus_addr(i_bus_addr), .i_bus_wdata(i_bus_wdata),
		.i_ovly_err(ovly_err), .i_fps(fps),
		.o_bus_ack(o_bus_ack), .o_bus_rdata(o_bus_rdata),
		.o_src_sel(cfg_src_sel), .o_ovly_en(cfg_ovly_en), .o_alpha(cfg_alpha),
		.o_width(cfg_width), .o_height(cfg_height), .o_err_clr(err_clr)
	);

	vid_source_sel u_source (
		.i_clk(i_clk), .pix_reset_sys(pix_reset_sys),
		.i_src_sel(cfg_src_sel), .i_width(cfg_width), .i_height(cfg_height),
		.i_rx_valid(i_rx_valid), .i_rx_data(i_rx_data),
		.i_rx_hlast(i_rx_hlast), .i_rx_vlast(i_rx_vlast),
		.i_src_ready(src_ready), .o_rx_ready(o_rx_ready),
		.o_src_valid(src_valid), .o_src_data(src_data),
		.o_src_hlast(src_hlast), .o_src_vlast(src_vlast),
		.o_rx_frame(rx_frame)
	);

	vid_alpha_tag u_alpha (
		.i_clk(i_clk), .pix_reset_sys(pix_reset_sys),
		.i_alpha(cfg_alpha),
		.i_ovl_valid(i_ovl_valid), .i_ovl_data(i_ovl_data),
		.i_ovl_hlast(i_ovl_hlast), .i_ovl_vlast(i_ovl_vlast),
		.i_tag_ready(tag_ready), .o_ovl_ready(o_ovl_ready),
		.o_tag_valid(tag_valid), .o_tag_data(tag_data), .o_tag_alpha(tag_alpha),
		.o_tag_hlast(tag_hlast), .o_tag_vlast(tag_vlast)
	);

	vid_overlay_mix u_mix (
		.i_clk(i_clk), .pix_reset_sys(pix_reset_sys),
		.i_ovly_en(cfg_ovly_en), .i_err_clr(err_clr),
		.i_src_valid(src_valid), .i_src_data(src_data),
		.i_src_hlast(src_hlast), .i_src_vlast(src_vlast),
		.i_tag_valid(tag_valid), .i_tag_data(tag_data), .i_tag_alpha(tag_alpha),
		.i_tag_hlast(tag_hlast), .i_tag_vlast(tag_vlast),
		.i_vid_ready(i_vid_ready),
		.o_src_ready(src_ready), .o_tag_ready(tag_ready),
		.o_vid_valid(o_vid_valid), .o_vid_data(o_vid_data),
		.o_vid_hlast(o_vid_hlast), .o_vid_vlast(o_vid_vlast),
		.o_ovly_err(ovly_err)
	);

	vid_frame_rate u_fps (
		.i_clk(i_clk), .pix_reset_sys(pix_reset_sys),
		.i_frame(rx_frame), .o_fps(fps)
	);

endmodule

// File: hdl/vid_frame_rate.sv
// Frame rate meter counting frames per window with saturation at 255
`timescale 1ns/1ps

module vid_frame_rate (
	input  logic          i_clk,
	input  logic          pix_reset_sys,
	input  logic          i_frame,
	output vid_pkg::fps_t o_fps
);

	logic [31:0] win_cnt;
	logic        win_end;
	// Top bit marks overflow
	logic [8:0]  frm_cnt;

	////////////////////
	// Window timer
	////////////////////
	always_ff @(posedge i_clk or posedge pix_reset_sys) begin
		if (pix_reset_sys) begin
			win_cnt <= '0;
			win_end <= 1'b0;
		end else if (win_cnt >= vid_pkg::WINDOW_CYCLES - 1) begin
			win_cnt <= '0;
			win_end <= 1'b1;
		end else begin
			win_cnt <= win_cnt + 1'b1;
			win_end <= 1'b0;
		end
	end

	// Frames in the window, a pulse on the end cycle opens the next one
	always_ff @(posedge i_clk or posedge pix_reset_sys) begin
		if (pix_reset_sys)
			frm_cnt <= '0;
		else if (win_end)
			frm_cnt <= {8'd0, i_frame};
		else if (i_frame && !frm_cnt[8])
			frm_cnt <= frm_cnt + 1'b1;
	end

	always_ff @(posedge i_clk or posedge pix_reset_sys) begin
		if (pix_reset_sys)
			o_fps <= '0;
		else if (win_end)
			o_fps <= frm_cnt[8] ? 8'hff : frm_cnt[7:0];
	end

endmodule

// File: hdl/vid_overlay_mix.sv
// Overlay mixer joining primary and tagged streams with sticky framing error
`timescale 1ns/1ps

module vid_overlay_mix (
	input  logic            i_clk,
	input  logic            pix_reset_sys,
	input  logic            i_ovly_en,
	input  logic            i_err_clr,
	input  logic            i_src_valid,
	input  vid_pkg::pixel_t i_src_data,
	input  logic            i_src_hlast,
	input  logic            i_src_vlast,
	input  logic            i_tag_valid,
	input  vid_pkg::pixel_t i_tag_data,
	input  vid_pkg::alpha_t i_tag_alpha,
	input  logic            i_tag_hlast,
	input  logic            i_tag_vlast,
	input  logic            i_vid_ready,
	output logic            o_src_ready,
	output logic            o_tag_ready,
	output logic            o_vid_valid,
	output vid_pkg::pixel_t o_vid_data,
	output logic            o_vid_hlast,
	output logic            o_vid_vlast,
	output logic            o_ovly_err
);

	logic            can_load;
	logic            load;
	logic            frame_mismatch;
	vid_pkg::pixel_t mix_data;

	// Per channel average, rounded down
	function automatic vid_pkg::pixel_t blend_avg(input vid_pkg::pixel_t a,
		input vid_pkg::pixel_t b);
		logic [8:0]      sum;
		vid_pkg::pixel_t res;
		for (int k = 0; k < 3; k++) begin
			sum = {1'b0, a[8*k +: 8]} + {1'b0, b[8*k +: 8]};
			res[8*k +: 8] = sum[8:1];
		end
		return res;
	endfunction

	////////////////////
	// Join
	////////////////////
	// Output register empty or draining
	assign can_load = !o_vid_valid || i_vid_ready;
	// Overlay on means both sides move together
	assign o_src_ready = can_load && (!i_ovly_en || i_tag_valid);
	assign o_tag_ready = can_load && i_ovly_en && i_src_valid;
	assign load = i_src_valid && o_src_ready;

	assign frame_mismatch = (i_src_hlast != i_tag_hlast) || (i_src_vlast != i_tag_vlast);

	always_comb begin
		if (!i_ovly_en) begin
			mix_data = i_src_data;
		end else begin
			case (i_tag_alpha)
			vid_pkg::ALPHA_CLEAR: mix_data = i_src_data;
			vid_pkg::ALPHA_OPAQUE: mix_data = i_tag_data;
			default: mix_data = blend_avg(i_src_data, i_tag_data);
			endcase
		end
	end

	always_ff @(posedge i_clk or posedge pix_reset_sys) begin
		if (pix_reset_sys) begin
			o_vid_valid <= 1'b0;
			o_ovly_err <= 1'b0;
		end else begin
			if (load)
				o_vid_valid <= 1'b1;
			else if (i_vid_ready)
				o_vid_valid <= 1'b0;
			// Sticky until cleared over the bus
			if (i_err_clr)
				o_ovly_err <= 1'b0;
			else if (load && i_ovly_en && frame_mismatch)
				o_ovly_err <= 1'b1;
		end
	end

	// Flags come from the primary
	always_ff @(posedge i_clk) begin
		if (load) begin
			o_vid_data <= mix_data;
			o_vid_hlast <= i_src_hlast;
			o_vid_vlast <= i_src_vlast;
		end
	end

	a_out_hold: assert property (@(posedge i_clk) disable iff (pix_reset_sys)
		(o_vid_valid && !i_vid_ready) |=> (o_vid_valid && $stable(o_vid_data)))
		else $error("output pixel changed while stalled");

endmodule

// File: hdl/vid_alpha_tag.sv
// Overlay alpha tagging with transparency detection through a skid buffer
`timescale 1ns/1ps

module vid_alpha_tag (
	input  logic            i_clk,
	input  logic            pix_reset_sys,
	input  vid_pkg::alpha_t i_alpha,
	input  logic            i_ovl_valid,
	input  vid_pkg::pixel_t i_ovl_data,
	input  logic            i_ovl_hlast,
	input  logic            i_ovl_vlast,
	input  logic            i_tag_ready,
	output logic            o_ovl_ready,
	output logic            o_tag_valid,
	output vid_pkg::pixel_t o_tag_data,
	output vid_pkg::alpha_t o_tag_alpha,
	output logic            o_tag_hlast,
	output logic            o_tag_vlast
);

	// Word layout is vlast, hlast, alpha, pixel
	logic            rdy_en;
	logic            skid_valid;
	logic [27:0]     skid_word;
	logic [27:0]     out_word;
	logic [27:0]     in_word;
	vid_pkg::alpha_t in_alpha;
	logic            in_fire;
	logic            out_load;

	// Transparent pixels always show the primary
	assign in_alpha = (i_ovl_data == vid_pkg::TRANSPARENT) ? vid_pkg::ALPHA_CLEAR : i_alpha;
	assign in_word = {i_ovl_vlast, i_ovl_hlast, in_alpha, i_ovl_data};

	// Held low for one cycle out of reset, then low only when the skid is full
	assign o_ovl_ready = rdy_en && !skid_valid;
	assign in_fire = i_ovl_valid && o_ovl_ready;
	assign out_load = !o_tag_valid || i_tag_ready;

	always_ff @(posedge i_clk or posedge pix_reset_sys) begin
		if (pix_reset_sys) begin
			rdy_en <= 1'b0;
			skid_valid <= 1'b0;
			o_tag_valid <= 1'b0;
		end else begin
			rdy_en <= 1'b1;
			if (out_load) begin
				// Skid drains first
				o_tag_valid <= skid_valid || in_fire;
				skid_valid <= 1'b0;
			end else if (in_fire) begin
				skid_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (out_load) begin
			if (skid_valid)
				out_word <= skid_word;
			else if (in_fire)
				out_word <= in_word;
		end else if (in_fire) begin
			skid_word <= in_word;
		end
	end

	assign {o_tag_vlast, o_tag_hlast, o_tag_alpha, o_tag_data} = out_word;

	a_tag_hold: assert property (@(posedge i_clk) disable iff (pix_reset_sys)
		(o_tag_valid && !i_tag_ready) |=> (o_tag_valid && $stable(out_word)))
		else $error("tagged pixel changed while stalled");

endmodule

// File: hdl/vid_source_sel.sv
// Empty frame generator and primary source selection
`timescale 1ns/1ps

module vid_source_sel (
	input  logic            i_clk,
	input  logic            pix_reset_sys,
	input  logic            i_src_sel,
	input  vid_pkg::dim_t   i_width,
	input  vid_pkg::dim_t   i_height,
	input  logic            i_rx_valid,
	input  vid_pkg::pixel_t i_rx_data,
	input  logic            i_rx_hlast,
	input  logic            i_rx_vlast,
	input  logic            i_src_ready,
	output logic            o_rx_ready,
	output logic            o_src_valid,
	output vid_pkg::pixel_t o_src_data,
	output logic            o_src_hlast,
	output logic            o_src_vlast,
	output logic            o_rx_frame
);

	typedef enum logic {
		SRC_IDLE,
		SRC_RUN
	} src_state_t;

	src_state_t    state;
	vid_pkg::dim_t col;
	vid_pkg::dim_t row;
	// Frame size latched at each frame start
	vid_pkg::dim_t frm_w;
	vid_pkg::dim_t frm_h;
	logic          gen_hlast;
	logic          gen_vlast;
	logic          size_ok;

	assign size_ok = (i_width != '0) && (i_height != '0);
	assign gen_hlast = (col == frm_w - 1'b1);
	assign gen_vlast = gen_hlast && (row == frm_h - 1'b1);

	////////////////////
	// Generator FSM
	////////////////////
	always_ff @(posedge i_clk or posedge pix_reset_sys) begin
		if (pix_reset_sys) begin
			state <= SRC_IDLE;
			col <= '0;
			row <= '0;
			frm_w <= '0;
			frm_h <= '0;
		end else if (i_src_sel) begin
			// Incoming stream owns the output
			state <= SRC_IDLE;
			col <= '0;
			row <= '0;
		end else if (state == SRC_IDLE) begin
			if (size_ok) begin
				state <= SRC_RUN;
				frm_w <= i_width;
				frm_h <= i_height;
			end
		end else if (i_src_ready) begin
			if (gen_vlast) begin
				// New size takes hold at the frame boundary
				col <= '0;
				row <= '0;
				frm_w <= i_width;
				frm_h <= i_height;
				if (!size_ok)
					state <= SRC_IDLE;
			end else if (gen_hlast) begin
				col <= '0;
				row <= row + 1'b1;
			end else begin
				col <= col + 1'b1;
			end
		end
	end

	// Source mux
	assign o_rx_ready = i_src_sel && i_src_ready;
	assign o_src_valid = i_src_sel ? i_rx_valid : (state == SRC_RUN);
	assign o_src_data = i_src_sel ? i_rx_data : vid_pkg::TRANSPARENT;
	assign o_src_hlast = i_src_sel ? i_rx_hlast : gen_hlast;
	assign o_src_vlast = i_src_sel ? i_rx_vlast : gen_vlast;

	// End of an incoming frame, one pulse per accepted last pixel
	assign o_rx_frame = i_rx_valid && o_rx_ready && i_rx_hlast && i_rx_vlast;

	a_col_range: assert property (@(posedge i_clk) disable iff (pix_reset_sys)
		(state == SRC_RUN) |-> (col < frm_w))
		else $error("generator column reached the width");

endmodule

// File: hdl/vid_ctrl_regs.sv
// Control register bank with two-stage bus acknowledge and configuration outputs
`timescale 1ns/1ps

module vid_ctrl_regs (
	input  logic               i_clk,
	input  logic               pix_reset_sys,
	input  logic               i_bus_stb,
	input  logic               i_bus_we,
	input  vid_pkg::bus_addr_t i_bus_addr,
	input  vid_pkg::bus_data_t i_bus_wdata,
	input  logic               i_ovly_err,
	input  vid_pkg::fps_t      i_fps,
	output logic               o_bus_ack,
	output vid_pkg::bus_data_t o_bus_rdata,
	output logic               o_src_sel,
	output logic               o_ovly_en,
	output vid_pkg::alpha_t    o_alpha,
	output vid_pkg::dim_t      o_width,
	output vid_pkg::dim_t      o_height,
	output logic               o_err_clr
);

	logic               wr_stb;
	logic               pre_ack;
	vid_pkg::bus_data_t pre_rdata;
	vid_pkg::bus_data_t rd_word;

	assign wr_stb = i_bus_stb && i_bus_we;

	// Status clear goes straight to the mixer, lands with the other writes
	assign o_err_clr = wr_stb && (i_bus_addr == vid_pkg::ADR_STATUS) && i_bus_wdata[0];

	////////////////////
	// Write decode
	////////////////////
	always_ff @(posedge i_clk or posedge pix_reset_sys) begin
		if (pix_reset_sys) begin
			o_src_sel <= 1'b0;
			o_ovly_en <= 1'b0;
			o_alpha <= 2'd0;
			o_width <= '0;
			o_height <= '0;
		end else if (wr_stb) begin
			case (i_bus_addr)
			vid_pkg::ADR_CONTROL: begin
				o_src_sel <= i_bus_wdata[0];
				o_ovly_en <= i_bus_wdata[1];
				o_alpha <= i_bus_wdata[5:4];
			end
			vid_pkg::ADR_SIZE: begin
				o_width <= i_bus_wdata[0 +: vid_pkg::LGDIM];
				o_height <= i_bus_wdata[16 +: vid_pkg::LGDIM];
			end
			default: begin
			end
			endcase
		end
	end

	////////////////////
	// Read word
	////////////////////
	always_comb begin
		// Unused bits stay zero
		rd_word = '0;
		case (i_bus_addr)
		vid_pkg::ADR_CONTROL: begin
			rd_word[0] = o_src_sel;
			rd_word[1] = o_ovly_en;
			rd_word[5:4] = o_alpha;
		end
		vid_pkg::ADR_SIZE: begin
			rd_word[0 +: vid_pkg::LGDIM] = o_width;
			rd_word[16 +: vid_pkg::LGDIM] = o_height;
		end
		vid_pkg::ADR_STATUS: rd_word[0] = i_ovly_err;
		vid_pkg::ADR_FPS: rd_word[7:0] = i_fps;
		default: rd_word = '0;
		endcase
	end

	// Ack pipe, stb then pre_ack then ack
	always_ff @(posedge i_clk or posedge pix_reset_sys) begin
		if (pix_reset_sys) begin
			pre_ack <= 1'b0;
			o_bus_ack <= 1'b0;
		end else begin
			pre_ack <= i_bus_stb;
			o_bus_ack <= pre_ack;
		end
	end

	// Read data follows the ack pipe
	always_ff @(posedge i_clk) begin
		if (i_bus_stb)
			pre_rdata <= i_bus_we ? '0 : rd_word;
		if (pre_ack)
			o_bus_rdata <= pre_rdata;
	end

	// Back to back acks need back to back requests
	a_ack_pair: assert property (@(posedge i_clk) disable iff (pix_reset_sys)
		(o_bus_ack && $past(o_bus_ack)) |-> $past(i_bus_stb, 2))
		else $error("bus ack repeated without a request");

endmodule

// File: hdl/vid_pkg.sv
// Video overlay package with shared widths, register map, alpha codes and window length
package vid_pkg;

	////////////////////
	// Widths
	////////////////////

	// Frame dimension and counter width, up to 4095x4095
	localparam int LGDIM = 12;

	typedef logic [LGDIM-1:0] dim_t;
	// RGB, red in the top byte
	typedef logic [23:0] pixel_t;
	typedef logic [1:0] alpha_t;
	typedef logic [3:0] bus_addr_t;
	typedef logic [31:0] bus_data_t;
	typedef logic [7:0] fps_t;

	////////////////////
	// Pixel and alpha codes
	////////////////////

	// Black overlay pixels are see-through
	localparam pixel_t TRANSPARENT = 24'h0;
	// Show only the primary
	localparam alpha_t ALPHA_CLEAR = 2'd3;
	// Show only the overlay; codes 1 and 2 average the two
	localparam alpha_t ALPHA_OPAQUE = 2'd0;

	// Register map
	localparam bus_addr_t ADR_CONTROL = 4'd0;
	localparam bus_addr_t ADR_SIZE = 4'd1;
	localparam bus_addr_t ADR_STATUS = 4'd2;
	localparam bus_addr_t ADR_FPS = 4'd3;

	// Frame rate window in i_clk cycles
	localparam logic [31:0] WINDOW_CYCLES = 32'd4000;

endpackage
